/* rtl/pma_pkg.sv */
// ======================================================================
// shared types and constants for the PMA checker
// attribute word is a plain 14-bit vector, fields found by the _LO offsets
// reset map is fixed here; regions 4 and 1 start unlocked
// ======================================================================

package pma_pkg;

	localparam int NUM_REGIONS = 8;

	typedef logic [2:0] region_idx_t;	// region number
	typedef logic [2:0] rights_t;		// bit 0 read, 1 write, 2 execute
	typedef logic [1:0] cache_pol_t;
	typedef logic [7:0] dev_type_t;
	typedef logic [13:0] region_attr_t;	// {lock, dev, cache, rights}

	// field offsets within region_attr_t
	localparam int ATTR_RIGHTS_LO = 0;
	localparam int ATTR_CACHE_LO = 3;
	localparam int ATTR_DEV_LO = 5;
	localparam int ATTR_LOCK = 13;

	// cache policy codes
	localparam cache_pol_t CACHE_NONE = 2'd0;
	localparam cache_pol_t CACHE_WT_RA = 2'd1;	// write-through, read allocate
	localparam cache_pol_t CACHE_WB = 2'd2;		// write-back

	localparam dev_type_t DEV_MEM = 8'h00;
	localparam dev_type_t DEV_DRAM = 8'h01;
	localparam dev_type_t DEV_VACANT = 8'hFF;	// any access faults

	typedef enum logic [1:0] {ACC_READ = 2'd0, ACC_WRITE = 2'd1, ACC_EXEC = 2'd2} access_kind_t;

	typedef enum logic [1:0] {
		FLD_RIGHTS = 2'd0,
		FLD_CACHE = 2'd1,
		FLD_DEV = 2'd2,
		FLD_LOCK = 2'd3
	} reg_field_t;

	// ==================================================================
	// reset memory map, index 7 first
	// ==================================================================
	localparam region_attr_t [NUM_REGIONS-1:0] PMA_DEFAULT_MAP = {
		{1'b1, DEV_MEM, CACHE_WT_RA, 3'b101},		// 7 rom, rx
		{1'b1, DEV_MEM, CACHE_NONE, 3'b011},		// 6 io, rw
		{1'b1, DEV_MEM, CACHE_NONE, 3'b011},		// 5 config, rw
		{1'b0, DEV_MEM, CACHE_WT_RA, 3'b111},		// 4 scratchpad, unlocked
		{1'b1, DEV_VACANT, CACHE_NONE, 3'b000},		// 3 vacant
		{1'b1, DEV_VACANT, CACHE_NONE, 3'b000},		// 2 vacant
		{1'b0, DEV_DRAM, CACHE_WT_RA, 3'b111},		// 1 dram, unlocked
		{1'b1, DEV_VACANT, CACHE_NONE, 3'b000}		// 0 vacant
	};

endpackage

/* rtl/pma_region_table.sv */
// ======================================================================
// eight-entry attribute table with a bare register port
// write lands at the next edge, read data one cycle after the address
// locked entries accept writes to the lock field only
// ======================================================================

module pma_region_table (
	input  logic clk,
	input  logic rst_i,
	input  logic reg_we_i,
	input  pma_pkg::region_idx_t reg_region_i,
	input  pma_pkg::reg_field_t reg_field_i,
	input  logic [7:0] reg_wdata_i,
	output logic [7:0] reg_rdata_o,
	output pma_pkg::region_attr_t [pma_pkg::NUM_REGIONS-1:0] attr_table_o
);
	import pma_pkg::*;

	region_attr_t [NUM_REGIONS-1:0] regions;	// live attribute words
	region_attr_t sel_entry;			// entry at the register address
	logic wr_ok;

	assign sel_entry = regions[reg_region_i];

	// lock field stays writable so software can unlock
	assign wr_ok = reg_we_i && (!sel_entry[ATTR_LOCK] || reg_field_i == FLD_LOCK);

	// ==================================================================
	// storage and write path
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			regions <= PMA_DEFAULT_MAP;	// fixed map out of reset
		end else if (wr_ok) begin
			case (reg_field_i)
				FLD_RIGHTS: begin
					regions[reg_region_i][ATTR_RIGHTS_LO +: $bits(rights_t)]
						<= reg_wdata_i[$bits(rights_t)-1:0];
				end
				FLD_CACHE: begin
					regions[reg_region_i][ATTR_CACHE_LO +: $bits(cache_pol_t)]
						<= reg_wdata_i[$bits(cache_pol_t)-1:0];
				end
				FLD_DEV: begin
					regions[reg_region_i][ATTR_DEV_LO +: $bits(dev_type_t)] <= reg_wdata_i;
				end
				default: begin
					regions[reg_region_i][ATTR_LOCK] <= reg_wdata_i[0];	// lock bit only
				end
			endcase
		end
	end

	// ==================================================================
	// read path, field zero-extended to 8 bits
	// ==================================================================
	always_ff @(posedge clk) begin
		case (reg_field_i)
			FLD_RIGHTS: reg_rdata_o <= 8'(sel_entry[ATTR_RIGHTS_LO +: $bits(rights_t)]);
			FLD_CACHE:  reg_rdata_o <= 8'(sel_entry[ATTR_CACHE_LO +: $bits(cache_pol_t)]);
			FLD_DEV:    reg_rdata_o <= sel_entry[ATTR_DEV_LO +: $bits(dev_type_t)];
			default:    reg_rdata_o <= 8'(sel_entry[ATTR_LOCK]);
		endcase
	end

	// flat bus to every lane
	assign attr_table_o = regions;

endmodule

/* rtl/pma_req_dispatch.sv */
// ======================================================================
// request dispatcher, one registered stage
// upstream must only send while it holds a credit, so the target lane
// at the write pointer is always free; no check is made here
// ======================================================================

module pma_req_dispatch #(
	parameter int NUM_LANES = 3
) (
	input  logic clk,
	input  logic rst_i,
	input  logic req_valid_i,
	input  pma_pkg::region_idx_t req_region_i,
	input  pma_pkg::access_kind_t req_kind_i,
	output logic req_credit_o,
	output logic [NUM_LANES-1:0] lane_load_o,
	output pma_pkg::region_idx_t load_region_o,
	output pma_pkg::access_kind_t load_kind_o,
	input  logic [NUM_LANES-1:0] lane_pop_i
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [PTR_W-1:0] wr_ptr;	// next lane to load, round-robin

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			lane_load_o <= '0;
			req_credit_o <= 1'b0;
		end else begin
			lane_load_o <= '0;	// single-cycle pulse
			if (req_valid_i) begin
				lane_load_o[wr_ptr] <= 1'b1;
				wr_ptr <= (wr_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : wr_ptr + 1'b1;
			end
			req_credit_o <= |lane_pop_i;	// freed lane -> one credit back
		end
	end

	// payload shared by all lanes, qualified by lane_load_o
	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			load_region_o <= req_region_i;
			load_kind_o <= req_kind_i;
		end
	end

endmodule

/* rtl/pma_check_lane.sv */
// ======================================================================
// one check lane: captures a lookup, holds the result until popped
// fault on vacant device type or missing right for the access kind
// load and pop never hit the same lane in one cycle
// ======================================================================

module pma_check_lane (
	input  logic clk,
	input  logic rst_i,
	input  logic load_i,
	input  pma_pkg::region_idx_t load_region_i,
	input  pma_pkg::access_kind_t load_kind_i,
	input  pma_pkg::region_attr_t [pma_pkg::NUM_REGIONS-1:0] attr_table_i,
	input  logic pop_i,
	output logic ready_o,
	output logic fault_o,
	output pma_pkg::region_attr_t attr_o
);
	import pma_pkg::*;

	region_attr_t sel_attr;	// entry of the loaded region
	rights_t sel_rights;
	dev_type_t sel_dev;
	logic miss;		// right not granted

	assign sel_attr = attr_table_i[load_region_i];
	assign sel_rights = sel_attr[ATTR_RIGHTS_LO +: $bits(rights_t)];
	assign sel_dev = sel_attr[ATTR_DEV_LO +: $bits(dev_type_t)];

	always_comb begin
		case (load_kind_i)
			ACC_READ:  miss = !sel_rights[0];
			ACC_WRITE: miss = !sel_rights[1];
			ACC_EXEC:  miss = !sel_rights[2];
			default:   miss = 1'b1;	// undefined kind, deny
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			ready_o <= 1'b0;
		else if (load_i)
			ready_o <= 1'b1;
		else if (pop_i)
			ready_o <= 1'b0;	// merger took it
	end

	// result payload
	always_ff @(posedge clk) begin
		if (load_i) begin
			fault_o <= (sel_dev == DEV_VACANT) || miss;
			attr_o <= sel_attr;
		end
	end

endmodule

/* rtl/pma_resp_merge.sv */
// ======================================================================
// response merger: drains lanes in dispatch order under credits
// read pointer walks the lanes exactly as the dispatcher's write pointer
// downstream returns at most one credit per cycle
// ======================================================================

module pma_resp_merge #(
	parameter int NUM_LANES = 3,
	parameter int RESP_CREDITS = 2
) (
	input  logic clk,
	input  logic rst_i,
	input  logic [NUM_LANES-1:0] lane_ready_i,
	input  logic [NUM_LANES-1:0] lane_fault_i,
	input  pma_pkg::region_attr_t [NUM_LANES-1:0] lane_attr_i,
	output logic [NUM_LANES-1:0] lane_pop_o,
	input  logic resp_credit_i,
	output logic resp_valid_o,
	output logic resp_fault_o,
	output pma_pkg::region_attr_t resp_attr_o
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int CRED_W = $clog2(RESP_CREDITS + 1);

	logic [PTR_W-1:0] rd_ptr;	// oldest outstanding lane
	logic [CRED_W-1:0] credits;	// downstream credits held
	logic fire;			// send this cycle

	assign fire = lane_ready_i[rd_ptr] && (credits != '0);

	// pop is combinational so the lane clears on the same edge
	always_comb begin
		lane_pop_o = '0;
		if (fire)
			lane_pop_o[rd_ptr] = 1'b1;
	end

	// ==================================================================
	// pointer, credit counter and valid
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_ptr <= '0;
			credits <= CRED_W'(RESP_CREDITS);
			resp_valid_o <= 1'b0;
		end else begin
			resp_valid_o <= fire;
			if (fire)
				rd_ptr <= (rd_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : rd_ptr + 1'b1;
			case ({fire, resp_credit_i})
				2'b10: credits <= credits - 1'b1;	// spent
				2'b01: credits <= credits + 1'b1;	// returned
				default: credits <= credits;		// both or neither
			endcase
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (fire) begin
			resp_fault_o <= lane_fault_i[rd_ptr];
			resp_attr_o <= lane_attr_i[rd_ptr];
		end
	end

endmodule

/* rtl/pma_unit_top.sv */
// ======================================================================
// PMA checker top: region table, dispatcher, check lanes, merger
// upstream starts with NUM_LANES credits, downstream grants RESP_CREDITS
// best-case latency req_valid_i to resp_valid_o is 3 cycles
// ======================================================================

module pma_unit_top #(
	parameter int NUM_LANES = 3,
	parameter int RESP_CREDITS = 2
) (
	input  logic clk,
	input  logic rst_i,
	// register port
	input  logic reg_we_i,
	input  pma_pkg::region_idx_t reg_region_i,
	input  pma_pkg::reg_field_t reg_field_i,
	input  logic [7:0] reg_wdata_i,
	output logic [7:0] reg_rdata_o,
	// request stream
	input  logic req_valid_i,
	input  pma_pkg::region_idx_t req_region_i,
	input  pma_pkg::access_kind_t req_kind_i,
	output logic req_credit_o,
	// response stream
	input  logic resp_credit_i,
	output logic resp_valid_o,
	output logic resp_fault_o,
	output pma_pkg::region_attr_t resp_attr_o
);
	import pma_pkg::*;

	region_attr_t [NUM_REGIONS-1:0] attr_table;
	logic [NUM_LANES-1:0] lane_load, lane_pop, lane_ready, lane_fault;
	region_attr_t [NUM_LANES-1:0] lane_attr;
	region_idx_t load_region;
	access_kind_t load_kind;

	pma_region_table u_table (
		.clk, .rst_i, .reg_we_i, .reg_region_i, .reg_field_i, .reg_wdata_i,
		.reg_rdata_o, .attr_table_o(attr_table)
	);

	pma_req_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
		.clk, .rst_i, .req_valid_i, .req_region_i, .req_kind_i, .req_credit_o,
		.lane_load_o(lane_load), .load_region_o(load_region), .load_kind_o(load_kind),
		.lane_pop_i(lane_pop)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		pma_check_lane u_lane (
			.clk, .rst_i, .load_i(lane_load[i]), .load_region_i(load_region),
			.load_kind_i(load_kind), .attr_table_i(attr_table), .pop_i(lane_pop[i]),
			.ready_o(lane_ready[i]), .fault_o(lane_fault[i]), .attr_o(lane_attr[i])
		);
	end

	pma_resp_merge #(.NUM_LANES(NUM_LANES), .RESP_CREDITS(RESP_CREDITS)) u_merge (
		.clk, .rst_i, .lane_ready_i(lane_ready), .lane_fault_i(lane_fault),
		.lane_attr_i(lane_attr), .lane_pop_o(lane_pop), .resp_credit_i,
		.resp_valid_o, .resp_fault_o, .resp_attr_o
	);

endmodule

/* dv/pma_tb_clkgen.sv */
// ======================================================================
// free-running testbench clock, starts low, 40 ns by default
// ======================================================================

module pma_tb_clkgen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk_o = 1'b0;
	always #(PERIOD_NS / 2) clk_o = ~clk_o;	// half period per toggle

endmodule

/* dv/pma_unit_chk.sv */
// ======================================================================
// concurrent checks on the credit streams and the lane handshake
// bound into the top, where dispatcher and merger signals meet
// downstream credits are tracked here from pops and returns
// ======================================================================

module pma_unit_chk #(
	parameter int NUM_LANES = 3,
	parameter int RESP_CREDITS = 2
) (
	input logic clk,
	input logic rst_i,
	input logic [NUM_LANES-1:0] lane_load_i,
	input logic [NUM_LANES-1:0] lane_ready_i,
	input logic [NUM_LANES-1:0] lane_pop_i,
	input logic resp_credit_i,
	input logic resp_valid_i,
	input logic req_credit_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int cred;		// downstream credits held by the merger
	int fail_count = 0;	// assertion failures so far

	always_ff @(posedge clk) begin
		if (rst_i)
			cred <= RESP_CREDITS;
		else
			cred <= cred - int'(|lane_pop_i) + int'(resp_credit_i);
	end

	// a pop is a send, so a credit must be in hand
	a_send_credit: assert property (@(posedge clk) disable iff (rst_i)
		|lane_pop_i |-> cred > 0)
		else begin
			$error("response sent with no downstream credit");
			fail_count++;
		end

	// credits keep a loaded lane free
	a_load_free: assert property (@(posedge clk) disable iff (rst_i)
		(lane_load_i & lane_ready_i) == '0)
		else begin
			$error("lane loaded while still holding a result");
			fail_count++;
		end

	a_reset_quiet: assert property (@(posedge clk)
		rst_i |=> !req_credit_i && !resp_valid_i && lane_load_i == '0 && lane_ready_i == '0)
		else begin
			$error("outputs not idle after reset");
			fail_count++;
		end

endmodule

bind pma_unit_top pma_unit_chk #(.NUM_LANES(NUM_LANES), .RESP_CREDITS(RESP_CREDITS)) u_chk (
	.clk(clk), .rst_i(rst_i), .lane_load_i(lane_load), .lane_ready_i(lane_ready),
	.lane_pop_i(lane_pop), .resp_credit_i(resp_credit_i), .resp_valid_i(resp_valid_o),
	.req_credit_i(req_credit_o)
);

/* dv/pma_unit_tb.sv */
// ======================================================================
// PMA checker testbench, DUT at default parameters (3 lanes, 2 credits)
// model table built from the documented reset map, same lock rule
// inputs change on the falling edge, outputs sampled on the rising edge
// ======================================================================

module pma_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pma_pkg::*;

	localparam int LANES = 3;		// DUT default
	localparam int RESP_CREDITS = 2;
	localparam int PLANNED_REQS = 24 + 12 + 40;
	localparam int WATCHDOG_NS = PLANNED_REQS * 200 * 40;	// 200 cycles per request

	logic clk, rst_i, reg_we_i, req_valid_i, resp_credit_i;
	region_idx_t reg_region_i, req_region_i;
	reg_field_t reg_field_i;
	logic [7:0] reg_wdata_i, reg_rdata_o;
	access_kind_t req_kind_i;
	logic req_credit_o, resp_valid_o, resp_fault_o;
	region_attr_t resp_attr_o;

	region_attr_t model_tbl [NUM_REGIONS];	// expected table contents
	logic [14:0] exp_q [$];			// {fault, attr} in request order
	int errors = 0, sent = 0, consumed = 0, returned = 0, credit_pulses = 0;
	int up_credits = LANES;
	int owed = 0;				// responses not yet credited back
	logic bp_en = 1'b0;			// long downstream stalls

	pma_tb_clkgen #(.PERIOD_NS(40)) u_clk (.clk_o(clk));

	pma_unit_top uut (.clk, .rst_i, .reg_we_i, .reg_region_i, .reg_field_i, .reg_wdata_i,
		.reg_rdata_o, .req_valid_i, .req_region_i, .req_kind_i, .req_credit_o,
		.resp_credit_i, .resp_valid_o, .resp_fault_o, .resp_attr_o);

	// ==================================================================
	// reference model
	// ==================================================================
	function automatic logic [14:0] expected_result(region_idx_t r, access_kind_t k);
		region_attr_t a;
		logic fault;
		a = model_tbl[r];
		fault = (a[12:5] == 8'hFF) || !a[int'(k)];	// vacant, or right bit k missing
		return {fault, a};
	endfunction

	function automatic logic [7:0] field_value(region_idx_t r, reg_field_t f);
		case (f)
			FLD_RIGHTS: return {5'd0, model_tbl[r][2:0]};
			FLD_CACHE:  return {6'd0, model_tbl[r][4:3]};
			FLD_DEV:    return model_tbl[r][12:5];
			default:    return {7'd0, model_tbl[r][13]};
		endcase
	endfunction

	task automatic reg_write(region_idx_t r, reg_field_t f, logic [7:0] d);
		@(negedge clk);
		reg_we_i = 1'b1;
		reg_region_i = r;
		reg_field_i = f;
		reg_wdata_i = d;
		if (!model_tbl[r][13] || f == FLD_LOCK) begin	// locked: lock field only
			case (f)
				FLD_RIGHTS: model_tbl[r][2:0] = d[2:0];
				FLD_CACHE:  model_tbl[r][4:3] = d[1:0];
				FLD_DEV:    model_tbl[r][12:5] = d;
				default:    model_tbl[r][13] = d[0];
			endcase
		end
		@(negedge clk);
		reg_we_i = 1'b0;
	endtask

	task automatic reg_check(region_idx_t r, reg_field_t f);
		@(negedge clk);
		reg_region_i = r;
		reg_field_i = f;
		@(negedge clk);		// data registered one edge later
		if (reg_rdata_o !== field_value(r, f)) begin
			errors++;
			$display("mismatch at %0t: region %0d field %s read %h, expected %h",
				$time, r, f.name(), reg_rdata_o, field_value(r, f));
		end
	endtask

	task automatic send_req(region_idx_t r, access_kind_t k);
		@(negedge clk);
		req_valid_i = 1'b0;
		while (up_credits == 0)
			@(negedge clk);	// stall until a lane frees
		req_valid_i = 1'b1;
		req_region_i = r;
		req_kind_i = k;
		up_credits--;
		sent++;
		exp_q.push_back(expected_result(r, k));
	endtask

	task automatic drain();
		@(negedge clk);
		req_valid_i = 1'b0;
		while (exp_q.size() != 0 || owed != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);	// last credit return gets counted
		if (credit_pulses != consumed) begin
			errors++;
			$display("upstream credit pulses %0d differ from responses consumed %0d",
				credit_pulses, consumed);
		end
		if (up_credits != LANES) begin
			errors++;
			$display("upstream credits at %0d after drain, expected %0d",
				up_credits, LANES);
		end
	endtask

	// ==================================================================
	// compare and credit counting
	// ==================================================================
	always @(posedge clk) begin : compare
		logic [14:0] want;
		if (!rst_i) begin
			if (req_credit_o) begin
				credit_pulses++;
				up_credits++;
			end
			if (resp_credit_i)
				returned++;
			if (resp_valid_o) begin
				consumed++;
				owed++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("response at %0t with no request outstanding", $time);
				end else begin
					want = exp_q.pop_front();
					if ({resp_fault_o, resp_attr_o} !== want) begin
						errors++;
						$display("mismatch at %0t: fault %b attr %h, expected fault %b attr %h",
							$time, resp_fault_o, resp_attr_o, want[14], want[13:0]);
					end
				end
				if (consumed - returned > RESP_CREDITS) begin
					errors++;
					$display("more responses than downstream credits granted at %0t", $time);
				end
			end
		end
	end

	// downstream returns one credit per response, after a random gap
	initial begin : downstream
		int gap;
		resp_credit_i = 1'b0;
		forever begin
			@(negedge clk);
			resp_credit_i = 1'b0;
			if (owed > 0 && !rst_i) begin
				gap = bp_en ? $urandom_range(12, 0) : $urandom_range(2, 0);
				repeat (gap) @(negedge clk);
				resp_credit_i = 1'b1;
				owed--;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("run hung: watchdog expired at %0t with %0d of %0d responses",
			$time, consumed, sent);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin : stimulus
		region_idx_t touched [4];
		void'($urandom(32'h54c8_2c4e));
		rst_i = 1'b1;
		reg_we_i = 1'b0;
		reg_region_i = '0;
		reg_field_i = FLD_RIGHTS;
		reg_wdata_i = '0;
		req_valid_i = 1'b0;
		req_region_i = '0;
		req_kind_i = ACC_READ;
		// documented reset map, {lock, dev, cache, rights}
		model_tbl[7] = {1'b1, 8'h00, CACHE_WT_RA, 3'b101};	// rom
		model_tbl[6] = {1'b1, 8'h00, CACHE_NONE, 3'b011};	// io
		model_tbl[5] = {1'b1, 8'h00, CACHE_NONE, 3'b011};	// config
		model_tbl[4] = {1'b0, 8'h00, CACHE_WT_RA, 3'b111};	// scratchpad
		model_tbl[3] = {1'b1, 8'hFF, CACHE_NONE, 3'b000};
		model_tbl[2] = {1'b1, 8'hFF, CACHE_NONE, 3'b000};
		model_tbl[1] = {1'b0, 8'h01, CACHE_WT_RA, 3'b111};	// dram
		model_tbl[0] = {1'b1, 8'hFF, CACHE_NONE, 3'b000};
		repeat (2) @(negedge clk);
		rst_i = 1'b0;

		// every region, every kind, against the reset map
		for (int r = 0; r < NUM_REGIONS; r++)
			for (int k = 0; k < 3; k++)
				send_req(region_idx_t'(r), access_kind_t'(k));
		drain();

		// register port and lock rule
		reg_write(3'd4, FLD_RIGHTS, 8'h01);	// scratchpad read only
		reg_write(3'd4, FLD_CACHE, 8'h02);
		reg_write(3'd4, FLD_DEV, 8'h5A);
		reg_write(3'd1, FLD_DEV, 8'hFF);	// dram goes vacant
		reg_write(3'd7, FLD_RIGHTS, 8'h07);	// locked, ignored
		reg_write(3'd6, FLD_DEV, 8'hFF);	// locked, ignored
		reg_check(3'd7, FLD_RIGHTS);
		reg_write(3'd7, FLD_LOCK, 8'h00);	// unlock rom
		reg_write(3'd7, FLD_RIGHTS, 8'h07);
		reg_write(3'd4, FLD_LOCK, 8'h01);
		reg_write(3'd4, FLD_RIGHTS, 8'h07);	// now ignored
		touched = '{3'd4, 3'd1, 3'd7, 3'd6};
		for (int i = 0; i < 4; i++)
			for (int f = 0; f < 4; f++)
				reg_check(touched[i], reg_field_t'(f));

		// lookups see the new rights and device types
		for (int i = 0; i < 4; i++)
			for (int k = 0; k < 3; k++)
				send_req(touched[i], access_kind_t'(k));
		drain();

		// random traffic with long credit stalls
		bp_en = 1'b1;
		for (int n = 0; n < 40; n++)
			send_req(region_idx_t'($urandom_range(7, 0)), access_kind_t'($urandom_range(2, 0)));
		drain();
		bp_en = 1'b0;

		if (sent != consumed) begin
			errors++;
			$display("%0d requests sent but %0d responses received", sent, consumed);
		end
		errors += uut.u_chk.fail_count;	// assertion failures
		$display("errors %0d, requests %0d, responses %0d, upstream credits %0d",
			errors, sent, consumed, up_credits);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* project.f */
rtl/pma_pkg.sv
rtl/pma_region_table.sv
rtl/pma_req_dispatch.sv
rtl/pma_check_lane.sv
rtl/pma_resp_merge.sv
rtl/pma_unit_top.sv
dv/pma_tb_clkgen.sv
dv/pma_unit_chk.sv
dv/pma_unit_tb.sv

/* Bender.yml */
package:
  name: pma_unit

sources:
  - rtl/pma_pkg.sv
  - rtl/pma_region_table.sv
  - rtl/pma_req_dispatch.sv
  - rtl/pma_check_lane.sv
  - rtl/pma_resp_merge.sv
  - rtl/pma_unit_top.sv
  - target: test
    files:
      - dv/pma_tb_clkgen.sv
      - dv/pma_unit_chk.sv
      - dv/pma_unit_tb.sv
